/* verilog/regex_cfg.svh */
`ifndef REGEX_CFG_SVH
`define REGEX_CFG_SVH

// program counter and operand width
`define REGEX_PC_WIDTH 8

`define REGEX_CHAR_WIDTH 8

// one instruction word from memory
`define REGEX_INSTR_WIDTH 16

`define REGEX_FIFO_DEPTH_LOG2 4 // 16 threads

`endif

/* verilog/regex_pkg.sv */
`default_nettype none

`include "regex_cfg.svh"

package regex_pkg;

  typedef logic [`REGEX_PC_WIDTH-1:0] pc_t;

  typedef enum logic [2:0] {
    OP_CHAR   = 3'd0,
    OP_ANY    = 3'd1,
    OP_JMP    = 3'd2,
    OP_SPLIT  = 3'd3,
    OP_ACCEPT = 3'd4,
    OP_FAIL   = 3'd5
  } opcode_e;

  // opcode in the top bits, operand in the low byte
  typedef struct packed {
    opcode_e                                         opcode;
    logic [(`REGEX_INSTR_WIDTH-3-`REGEX_PC_WIDTH)-1:0] unused;
    logic [`REGEX_PC_WIDTH-1:0]                      operand; // char or target pc
  } instr_t;

  typedef enum logic [2:0] {
    DEC_IDLE, DEC_POP, DEC_FETCH, DEC_MEM_END, DEC_OFFER
  } decode_state_e;

  typedef enum logic [2:0] {
    EXE_IDLE, EXE_TAKE, EXE_PUSH, EXE_PUSH_END, EXE_EMIT, EXE_EMIT_END
  } execute_state_e;

endpackage

`default_nettype wire

/* verilog/regex_dec_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regex_cfg.svh"

// decoded instruction, four-phase from decode to execute
interface regex_dec_if
  import regex_pkg::*;
();

  logic                       req;
  logic                       ack;
  pc_t                        pc;      // pc of the thread
  opcode_e                    opcode;
  logic [`REGEX_PC_WIDTH-1:0] operand;

  modport source (
    output req, pc, opcode, operand,
    input  ack
  );

  modport sink (
    input  req, pc, opcode, operand,
    output ack
  );

endinterface

`default_nettype wire

/* verilog/thread_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regex_cfg.svh"

module thread_fifo
  import regex_pkg::*;
#(
  parameter int depth_log2 = `REGEX_FIFO_DEPTH_LOG2
) (
  input  wire      clk,
  input  wire      rst_n,
  input  wire      in_req,
  input  wire pc_t in_pc,
  output logic     in_ack,
  input  wire      push_req,
  input  wire pc_t push_pc,
  output logic     push_ack,
  output logic     pop_req,
  output pc_t      pop_pc,
  input  wire      pop_ack,
  output logic     empty
);

  localparam int depth = 1 << depth_log2;
  // injection keeps two slots free for threads coming back from execute
  localparam logic [depth_log2:0] in_limit = (depth_log2 + 1)'(depth - 2);
  localparam logic [depth_log2:0] full_count = (depth_log2 + 1)'(depth);

  pc_t                   mem [depth];
  logic [depth_log2-1:0] wr_ptr;
  logic [depth_log2-1:0] rd_ptr;
  logic [depth_log2:0]   count;
  logic                  in_first; // round robin, injection wins next tie
  logic                  pop_ack_q;
  logic                  in_pend, push_pend;
  logic                  grant_in, grant_push;
  logic                  wr_en, do_pop;

  always_comb begin
    in_pend    = in_req && !in_ack;
    push_pend  = push_req && !push_ack;
    grant_in   = in_pend && (count < in_limit) && (!push_pend || in_first);
    grant_push = push_pend && (count < full_count) && !grant_in;
    wr_en      = grant_in || grant_push;
    do_pop     = pop_ack && !pop_ack_q; // pop on rising ack
    empty      = (count == '0);
    pop_req    = !empty && !pop_ack;
    pop_pc     = mem[rd_ptr];
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= grant_in ? in_pc : push_pc;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_ack    <= 1'b0;
      push_ack  <= 1'b0;
      in_first  <= 1'b1;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pop_ack_q <= 1'b0;
    end else begin
      pop_ack_q <= pop_ack;
      if (grant_in) begin
        in_ack   <= 1'b1;
        in_first <= 1'b0;
      end else if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end
      if (grant_push) begin
        push_ack <= 1'b1;
        in_first <= 1'b1;
      end else if (push_ack && !push_req) begin
        push_ack <= 1'b0;
      end
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // none or both
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/regex_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module regex_decode
  import regex_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire         pop_req,
  input  wire pc_t    pop_pc,
  output logic        pop_ack,
  output logic        mem_req,
  output pc_t         mem_addr,
  input  wire instr_t mem_data,
  input  wire         mem_ack,
  regex_dec_if.source dec,
  output logic        busy
);

  decode_state_e state;

  assign busy = (state != DEC_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= DEC_IDLE;
      pop_ack <= 1'b0;
      mem_req <= 1'b0;
      dec.req <= 1'b0;
    end else begin
      case (state)
        DEC_IDLE: begin
          if (pop_req) begin
            mem_addr <= pop_pc; // thread pc doubles as fetch address
            pop_ack  <= 1'b1;
            state    <= DEC_POP;
          end
        end
        DEC_POP: begin
          if (!pop_req) begin
            pop_ack <= 1'b0;
            mem_req <= 1'b1;
            state   <= DEC_FETCH;
          end
        end
        DEC_FETCH: begin
          // mem_data only valid while mem_ack is high
          if (mem_ack) begin
            dec.pc      <= mem_addr;
            dec.opcode  <= mem_data.opcode;
            dec.operand <= mem_data.operand;
            mem_req     <= 1'b0;
            state       <= DEC_MEM_END;
          end
        end
        DEC_MEM_END: begin
          // execute may still be closing the previous transfer
          if (!mem_ack && !dec.ack) begin
            dec.req <= 1'b1;
            state   <= DEC_OFFER;
          end
        end
        DEC_OFFER: begin
          if (dec.ack) begin
            dec.req <= 1'b0;
            state   <= DEC_IDLE; // free to pop the next thread
          end
        end
        default: state <= DEC_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/regex_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regex_cfg.svh"

module regex_execute
  import regex_pkg::*;
(
  input  wire                         clk,
  input  wire                         rst_n,
  regex_dec_if.sink                   dec,
  input  wire [`REGEX_CHAR_WIDTH-1:0] cur_char,
  input  wire                         end_of_string,
  output logic                        push_req,
  output pc_t                         push_pc,
  input  wire                         push_ack,
  output logic                        emit_req,
  output pc_t                         emit_pc,
  input  wire                         emit_ack,
  output logic                        accept_hit,
  output logic                        busy
);

  execute_state_e             state;
  pc_t                        pc_q;
  opcode_e                    op_q;
  logic [`REGEX_PC_WIDTH-1:0] arg_q;
  logic                       second_push; // split target still to go
  pc_t                        next_pc;
  logic                       char_hit;

  assign next_pc  = pc_q + 1'b1;
  assign char_hit = (cur_char == arg_q) && !end_of_string;
  assign busy     = (state != EXE_IDLE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= EXE_IDLE;
      dec.ack     <= 1'b0;
      push_req    <= 1'b0;
      emit_req    <= 1'b0;
      accept_hit  <= 1'b0;
      second_push <= 1'b0;
    end else begin
      accept_hit <= 1'b0;
      case (state)
        EXE_IDLE: begin
          if (dec.req) begin
            pc_q    <= dec.pc;
            op_q    <= dec.opcode;
            arg_q   <= dec.operand;
            dec.ack <= 1'b1;
            state   <= EXE_TAKE;
          end
        end
        EXE_TAKE: begin
          if (!dec.req) begin
            dec.ack <= 1'b0;
            state   <= EXE_IDLE; // thread dies unless overridden below
            case (op_q)
              OP_CHAR, OP_ANY: begin
                if (op_q == OP_ANY ? !end_of_string : char_hit) begin
                  emit_pc  <= next_pc;
                  emit_req <= 1'b1;
                  state    <= EXE_EMIT;
                end
              end
              OP_JMP: begin
                push_pc  <= arg_q;
                push_req <= 1'b1;
                state    <= EXE_PUSH;
              end
              OP_SPLIT: begin
                push_pc     <= next_pc; // fall-through first
                push_req    <= 1'b1;
                second_push <= 1'b1;
                state       <= EXE_PUSH;
              end
              OP_ACCEPT: accept_hit <= end_of_string;
              default: ;
            endcase
          end
        end
        EXE_PUSH: begin
          if (push_ack) begin
            push_req <= 1'b0;
            state    <= EXE_PUSH_END;
          end
        end
        EXE_PUSH_END: begin
          if (!push_ack) begin
            if (second_push) begin
              push_pc     <= arg_q;
              push_req    <= 1'b1;
              second_push <= 1'b0;
              state       <= EXE_PUSH;
            end else begin
              state <= EXE_IDLE;
            end
          end
        end
        EXE_EMIT: begin
          if (emit_ack) begin
            emit_req <= 1'b0;
            state    <= EXE_EMIT_END;
          end
        end
        EXE_EMIT_END: if (!emit_ack) state <= EXE_IDLE;
        default: state <= EXE_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/regex_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regex_cfg.svh"

module regex_result
  import regex_pkg::*;
(
  input  wire      clk,
  input  wire      rst_n,
  input  wire      emit_req,
  input  wire pc_t emit_pc,
  output logic     emit_ack,
  input  wire      accept_hit,
  input  wire      next_char,
  input  wire      fifo_empty,
  input  wire      decode_busy,
  input  wire      execute_busy,
  output logic     out_req,
  output pc_t      out_pc,
  input  wire      out_ack,
  output logic     accepts,
  output logic     running
);

  logic [(1 << `REGEX_PC_WIDTH)-1:0] seen; // one bit per pc, per character
  logic                              pend;  // new pc waiting to leave
  logic                              sent;  // output acked, waiting for ack low

  assign running = !fifo_empty || decode_busy || execute_busy || pend || emit_ack
                   || accept_hit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seen     <= '0;
      emit_ack <= 1'b0;
      out_req  <= 1'b0;
      pend     <= 1'b0;
      sent     <= 1'b0;
      accepts  <= 1'b0;
    end else begin
      if (emit_ack && !emit_req) begin
        emit_ack <= 1'b0;
      end else if (emit_req && !emit_ack && !pend) begin
        if (seen[emit_pc]) begin
          emit_ack <= 1'b1; // duplicate, swallow it
        end else begin
          seen[emit_pc] <= 1'b1;
          out_pc        <= emit_pc;
          pend          <= 1'b1;
        end
      end
      if (pend && !sent && !out_req && !out_ack) out_req <= 1'b1;
      if (out_req && out_ack) begin
        out_req <= 1'b0;
        sent    <= 1'b1;
      end
      // release execute only once the output transfer is closed
      if (sent && !out_ack) begin
        sent     <= 1'b0;
        pend     <= 1'b0;
        emit_ack <= 1'b1;
      end
      if (next_char) begin
        seen    <= '0;
        accepts <= 1'b0;
      end else if (accept_hit) begin
        accepts <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/regex_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regex_cfg.svh"

module regex_engine
  import regex_pkg::*;
(
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          in_req,
  input  wire pc_t                     in_pc,
  output logic                         in_ack,
  input  wire [`REGEX_CHAR_WIDTH-1:0]  cur_char,
  input  wire                          end_of_string,
  input  wire                          next_char,
  output logic                         mem_req,
  output pc_t                          mem_addr,
  input  wire [`REGEX_INSTR_WIDTH-1:0] mem_data,
  input  wire                          mem_ack,
  output logic                         out_req,
  output pc_t                          out_pc,
  input  wire                          out_ack,
  output logic                         accepts,
  output logic                         running
);

  logic push_req, push_ack;
  pc_t  push_pc;
  logic pop_req, pop_ack;
  pc_t  pop_pc;
  logic fifo_empty;
  logic emit_req, emit_ack;
  pc_t  emit_pc;
  logic accept_hit;
  logic decode_busy, execute_busy;

  regex_dec_if dec_link ();

  thread_fifo u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_req   (in_req),
    .in_pc    (in_pc),
    .in_ack   (in_ack),
    .push_req (push_req),
    .push_pc  (push_pc),
    .push_ack (push_ack),
    .pop_req  (pop_req),
    .pop_pc   (pop_pc),
    .pop_ack  (pop_ack),
    .empty    (fifo_empty)
  );

  regex_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .pop_req  (pop_req),
    .pop_pc   (pop_pc),
    .pop_ack  (pop_ack),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_data (mem_data), // raw word, unpacked as instr_t
    .mem_ack  (mem_ack),
    .dec      (dec_link.source),
    .busy     (decode_busy)
  );

  regex_execute u_execute (
    .clk           (clk),
    .rst_n         (rst_n),
    .dec           (dec_link.sink),
    .cur_char      (cur_char),
    .end_of_string (end_of_string),
    .push_req      (push_req),
    .push_pc       (push_pc),
    .push_ack      (push_ack),
    .emit_req      (emit_req),
    .emit_pc       (emit_pc),
    .emit_ack      (emit_ack),
    .accept_hit    (accept_hit),
    .busy          (execute_busy)
  );

  regex_result u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .emit_req     (emit_req),
    .emit_pc      (emit_pc),
    .emit_ack     (emit_ack),
    .accept_hit   (accept_hit),
    .next_char    (next_char),
    .fifo_empty   (fifo_empty),
    .decode_busy  (decode_busy),
    .execute_busy (execute_busy),
    .out_req      (out_req),
    .out_pc       (out_pc),
    .out_ack      (out_ack),
    .accepts      (accepts),
    .running      (running)
  );

endmodule

`default_nettype wire

/* verification/regex_model.svh */
`ifndef REGEX_MODEL_SVH
`define REGEX_MODEL_SVH

localparam int prog_len    = 16;
localparam int max_threads = 18; // fifo slots plus the threads in decode and execute

instr_t       imem [256];
int unsigned  thread_cost [256]; // fifo entries caused by one thread at this pc
logic [255:0] exp_emit;          // pcs expected on out_pc
logic         exp_accept;

function automatic instr_t make_instr(input opcode_e op, input pc_t arg);
  instr_t i;
  i.opcode  = op;
  i.unused  = '0;
  i.operand = arg;
  return i;
endfunction

// targets always point forward, so a program never loops
task automatic gen_program();
  int unsigned r;
  opcode_e     op;
  pc_t         tgt;
  pc_t         chr;
  for (int a = 0; a < 256; a++) begin
    imem[pc_t'(a)] = make_instr(OP_FAIL, pc_t'(a)); // outside the program
  end
  for (int a = 0; a < prog_len - 1; a++) begin
    r   = $random(seed);
    tgt = pc_t'(a + 1 + int'((r >> 8) % 32'(prog_len - 1 - a)));
    chr = pc_t'(32'd97 + (r >> 4) % 32'd4); // 'a' to 'd'
    case (r % 32'd8)
      0, 1:    op = OP_CHAR;
      2:       op = OP_ANY;
      3:       op = OP_JMP;
      4, 5:    op = OP_SPLIT;
      6:       op = OP_ACCEPT;
      default: op = OP_FAIL;
    endcase
    imem[pc_t'(a)] = make_instr(op, (op == OP_CHAR) ? chr : tgt);
  end
  imem[pc_t'(prog_len - 1)] = make_instr(OP_ACCEPT, '0);
  // walk backwards so every target is already known
  for (int a = prog_len - 1; a >= 0; a--) begin
    thread_cost[pc_t'(a)] = 1;
    if (imem[pc_t'(a)].opcode == OP_JMP) begin
      thread_cost[pc_t'(a)] += thread_cost[imem[pc_t'(a)].operand];
    end else if (imem[pc_t'(a)].opcode == OP_SPLIT) begin
      thread_cost[pc_t'(a)] += thread_cost[pc_t'(a + 1)]
                               + thread_cost[imem[pc_t'(a)].operand];
    end
  end
endtask

// reachable set first, then the per-pc character rules
function automatic void model_char(input logic [255:0] injected, input char_t ch,
                                   input logic eos);
  logic [255:0] reach;
  instr_t       i;
  reach      = injected;
  exp_emit   = '0;
  exp_accept = 1'b0;
  for (int a = 0; a < prog_len; a++) begin
    if (reach[pc_t'(a)]) begin
      i = imem[pc_t'(a)];
      case (i.opcode)
        OP_CHAR:   if (i.operand == ch && !eos) exp_emit[pc_t'(a + 1)] = 1'b1;
        OP_ANY:    if (!eos) exp_emit[pc_t'(a + 1)] = 1'b1;
        OP_JMP:    reach[i.operand] = 1'b1;
        OP_SPLIT: begin
          reach[pc_t'(a + 1)] = 1'b1;
          reach[i.operand]    = 1'b1;
        end
        OP_ACCEPT: if (eos) exp_accept = 1'b1;
        default: ;
      endcase
    end
  end
endfunction

`endif

/* verification/regex_engine_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "regex_cfg.svh"

module regex_engine_tb
  import regex_pkg::*;
();

  typedef logic [`REGEX_CHAR_WIDTH-1:0] char_t;

  localparam int max_wait  = 2000; // cycles allowed for any single wait
  localparam int seed_init = 32'h6964_a3d2;

  logic                          clk = 1'b0;
  logic                          rst_n = 1'b0;
  logic                          in_req = 1'b0;
  pc_t                           in_pc = '0;
  logic                          in_ack;
  char_t                         cur_char = '0;
  logic                          end_of_string = 1'b0;
  logic                          next_char = 1'b0;
  logic                          mem_req;
  pc_t                           mem_addr;
  logic [`REGEX_INSTR_WIDTH-1:0] mem_data = '0;
  logic                          mem_ack = 1'b0;
  logic                          out_req;
  pc_t                           out_pc;
  logic                          out_ack = 1'b0;
  logic                          accepts;
  logic                          running;

  int          seed = seed_init;
  int          mem_seed = seed_init + 1; // responders draw from their own streams
  int          ack_seed = seed_init + 2;
  int unsigned mem_wait = 0;
  int unsigned ack_wait = 0;
  pc_t         got_q [$];

  `include "regex_model.svh"

  regex_engine uut (.*);

  always #4 clk = ~clk;

  // instruction memory, 0 to 3 cycles per fetch
  always @(posedge clk) begin
    if (!rst_n) begin
      mem_ack  <= 1'b0;
      mem_wait <= 0;
    end else if (mem_req && !mem_ack) begin
      if (mem_wait == 0) begin
        // every thread stays inside the program, so fetches do too
        if (mem_addr >= pc_t'(prog_len)) begin
          stop_on_error($sformatf("error: mem_addr got 0x%h limit 0x%h",
                                  mem_addr, pc_t'(prog_len)));
        end
        mem_data <= imem[mem_addr];
        mem_ack  <= 1'b1;
        mem_wait <= $unsigned($random(mem_seed)) % 32'd4;
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack <= 1'b0;
    end
  end

  // output collector with a slow ack
  always @(posedge clk) begin
    if (!rst_n) begin
      out_ack  <= 1'b0;
      ack_wait <= 0;
    end else if (out_req && !out_ack) begin
      if (ack_wait == 0) begin
        got_q.push_back(out_pc);
        out_ack  <= 1'b1;
        ack_wait <= $unsigned($random(ack_seed)) % 32'd8;
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end else if (!out_req && out_ack) begin
      out_ack <= 1'b0;
    end
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) stop_on_error($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_accept(input string name, input logic got, input logic exp);
    if (got !== exp) stop_on_error($sformatf("error: %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic inject_pc(input pc_t p);
    int n;
    @(posedge clk);
    in_pc  <= p;
    in_req <= 1'b1;
    n = 0;
    while (!in_ack) begin
      @(posedge clk);
      n++;
      if (n > max_wait) stop_on_error("in_ack did not rise for an injected thread");
    end
    in_req <= 1'b0;
    n = 0;
    while (in_ack) begin
      @(posedge clk);
      n++;
      if (n > max_wait) stop_on_error("in_ack did not fall after in_req dropped");
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (running) begin
      @(posedge clk);
      n++;
      if (n > max_wait) stop_on_error("running did not return low after the character");
    end
  endtask

  initial begin
    int unsigned  r;
    int unsigned  cost;
    pc_t          p;
    pc_t          inj_q [$];
    pc_t          exp_q [$];
    logic [255:0] inj_set;
    char_t        ch;
    logic         eos;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (in_ack || mem_req || out_req || accepts || running) begin
      stop_on_error("outputs were not low after reset");
    end
    for (int prog = 0; prog < 8; prog++) begin
      gen_program();
      for (int step = 0; step < 6; step++) begin
        r   = $random(seed);
        ch  = char_t'(32'd97 + r % 32'd4);
        eos = (r[9:8] == 2'b00); // about one character in four ends the string
        @(posedge clk);
        cur_char      <= ch;
        end_of_string <= eos;
        inj_q.delete();
        exp_q.delete();
        got_q.delete();
        inj_set = '0;
        cost    = 0;
        // burst of injections, capped so the fifo can never deadlock
        for (int t = 0; t < 24; t++) begin
          r = $random(seed);
          p = pc_t'(r % prog_len);
          if (cost + thread_cost[p] <= max_threads) begin
            inj_q.push_back(p);
            inj_set[p] = 1'b1;
            cost += thread_cost[p];
          end
        end
        model_char(inj_set, ch, eos);
        foreach (inj_q[k]) inject_pc(inj_q[k]);
        wait_idle();
        got_q.sort();
        for (int a = 0; a <= prog_len; a++) begin
          if (exp_emit[pc_t'(a)]) exp_q.push_back(pc_t'(a));
        end
        if (got_q.size() != exp_q.size()) begin
          stop_on_error($sformatf("out_pc gave %0d threads where %0d were expected",
                                  got_q.size(), exp_q.size()));
        end
        foreach (exp_q[k]) check_pc("out_pc", got_q[k], exp_q[k]);
        check_accept("accepts", accepts, exp_accept);
        @(posedge clk);
        next_char <= 1'b1;
        @(posedge clk);
        next_char <= 1'b0;
        @(posedge clk);
        check_accept("accepts", accepts, 1'b0); // cleared by next_char
      end
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verilog
+incdir+verification
verilog/regex_pkg.sv
verilog/regex_dec_if.sv
verilog/thread_fifo.sv
verilog/regex_decode.sv
verilog/regex_execute.sv
verilog/regex_result.sv
verilog/regex_engine.sv
verification/regex_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f sources.f --top-module regex_engine_tb -o regex_sim \
  && ./obj_dir/regex_sim | tee sim.log \
  && ! grep -q "Test failed" sim.log \
  && grep -q "Test passed" sim.log \
  || { echo "simulation did not pass"; exit 1; }
echo "simulation passed"
